/* rtl/givens_pkg.sv */
`default_nettype none

package givens_pkg;

    // width of each signed coordinate
    localparam int DATA_W = 14;

    // inverse CORDIC gain of about 0.607
    localparam int GAIN_FRAC = 10;
    localparam logic signed [GAIN_FRAC:0] GAIN_K = 11'sd622;

    typedef enum logic {
        ROT_FOLLOW = 1'b0,
        ROT_VECTOR = 1'b1
    } rot_mode_e;

    // 30-bit stream sample seen at the top level
    typedef struct packed {
        logic                     valid;
        rot_mode_e                mode;
        logic signed [DATA_W-1:0] x;
        logic signed [DATA_W-1:0] y;
    } rot_sample_t;

    // between pipeline stages
    // rotated is set once any micro-rotation has been applied
    typedef struct packed {
        rot_sample_t smp;
        logic        rotated;
    } pipe_sample_t;

endpackage

`default_nettype wire

/* rtl/cordic_prefold.sv */
`timescale 1ns/1ns
`default_nettype none

module cordic_prefold
    import givens_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  rot_sample_t  s_i,
    output pipe_sample_t s_o
);

    localparam logic signed [DATA_W-1:0] X_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    logic signed [DATA_W-1:0] x_in;
    logic signed [DATA_W-1:0] y_in;
    logic                     is_vec;
    logic                     fold;
    logic                     fold_q;
    logic                     valid_q;
    rot_mode_e                mode_q;
    logic signed [DATA_W-1:0] x_q;
    logic signed [DATA_W-1:0] y_q;

    assign x_in   = s_i.x;
    assign y_in   = s_i.y;
    assign is_vec = s_i.valid && (s_i.mode == ROT_VECTOR);

    // left half-plane goes to the right half-plane, followers reuse the fold
    assign fold = is_vec ? (x_in < 0) : fold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            fold_q  <= 1'b0;
        end else begin
            valid_q <= s_i.valid;
            if (is_vec) begin
                fold_q <= fold;
            end
        end
    end

    always_ff @(posedge clk) begin
        mode_q <= s_i.mode;
        x_q    <= fold ? -x_in : x_in;
        y_q    <= fold ? -y_in : y_in;
    end

    always_comb begin
        s_o.smp.valid = valid_q;
        s_o.smp.mode  = mode_q;
        s_o.smp.x     = x_q;
        s_o.smp.y     = y_q;
        s_o.rotated   = 1'b0;
    end

    // only the most negative x cannot be folded
    a_fold_nonneg: assert property (@(posedge clk) disable iff (!rst_n)
        is_vec && (x_in != X_MIN) |=> !s_o.smp.x[DATA_W-1]);

endmodule

`default_nettype wire

/* rtl/cordic_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module cordic_stage
    import givens_pkg::*;
#(
    parameter int SHIFT = 0
) (
    input  logic         clk,
    input  logic         rst_n,
    input  pipe_sample_t s_i,
    output pipe_sample_t s_o
);

    logic signed [DATA_W-1:0] x_in;
    logic signed [DATA_W-1:0] y_in;
    logic signed [DATA_W-1:0] x_sh;
    logic signed [DATA_W-1:0] y_sh;
    logic signed [DATA_W-1:0] x_nxt;
    logic signed [DATA_W-1:0] y_nxt;
    logic                     is_vec;
    logic                     dir;
    logic                     upd;
    logic                     dir_q;
    logic                     upd_q;
    logic                     valid_q;
    rot_mode_e                mode_q;
    logic signed [DATA_W-1:0] x_q;
    logic signed [DATA_W-1:0] y_q;
    logic                     rot_q;

    assign x_in   = s_i.smp.x;
    assign y_in   = s_i.smp.y;
    assign is_vec = s_i.smp.valid && (s_i.smp.mode == ROT_VECTOR);

    // vectoring decides, followers replay the last decision
    assign dir = is_vec ? (y_in > 0) : dir_q;
    assign upd = is_vec ? (y_in != 0) : upd_q;

    assign x_sh = x_in >>> SHIFT;
    assign y_sh = y_in >>> SHIFT;

    always_comb begin
        if (dir) begin
            x_nxt = x_in + y_sh;
            y_nxt = y_in - x_sh;
        end else begin
            x_nxt = x_in - y_sh;
            y_nxt = y_in + x_sh;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            dir_q   <= 1'b0;
            upd_q   <= 1'b0;
        end else begin
            valid_q <= s_i.smp.valid;
            if (is_vec) begin
                dir_q <= dir;
                upd_q <= upd;
            end
        end
    end

    always_ff @(posedge clk) begin
        mode_q <= s_i.smp.mode;
        x_q    <= upd ? x_nxt : x_in;
        y_q    <= upd ? y_nxt : y_in;
        rot_q  <= s_i.rotated | upd;
    end

    always_comb begin
        s_o.smp.valid = valid_q;
        s_o.smp.mode  = mode_q;
        s_o.smp.x     = x_q;
        s_o.smp.y     = y_q;
        s_o.rotated   = rot_q;
    end

endmodule

`default_nettype wire

/* rtl/cordic_gain.sv */
`timescale 1ns/1ns
`default_nettype none

module cordic_gain
    import givens_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  pipe_sample_t s_i,
    output rot_sample_t  s_o
);

    logic signed [DATA_W-1:0]        x_in;
    logic signed [DATA_W-1:0]        y_in;
    logic signed [DATA_W+GAIN_FRAC:0] x_prod;
    logic signed [DATA_W+GAIN_FRAC:0] y_prod;
    logic                            valid_q;
    rot_mode_e                       mode_q;
    logic signed [DATA_W-1:0]        x_q;
    logic signed [DATA_W-1:0]        y_q;

    assign x_in = s_i.smp.x;
    assign y_in = s_i.smp.y;

    // Q10 product whose integer part is kept below
    assign x_prod = x_in * GAIN_K;
    assign y_prod = y_in * GAIN_K;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= s_i.smp.valid;
        end
    end

    always_ff @(posedge clk) begin
        mode_q <= s_i.smp.mode;
        // no micro-rotation means no gain to undo
        if (s_i.rotated) begin
            x_q <= x_prod[GAIN_FRAC +: DATA_W];
            y_q <= y_prod[GAIN_FRAC +: DATA_W];
        end else begin
            x_q <= x_in;
            y_q <= y_in;
        end
    end

    always_comb begin
        s_o.valid = valid_q;
        s_o.mode  = mode_q;
        s_o.x     = x_q;
        s_o.y     = y_q;
    end

    a_idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !s_o.valid);

endmodule

`default_nettype wire

/* rtl/givens_rotator.sv */
`timescale 1ns/1ns
`default_nettype none

module givens_rotator
    import givens_pkg::*;
#(
    parameter int N_STAGES = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  rot_sample_t sample_i,
    output rot_sample_t sample_o
);

    // pipe[0] from the prefold, pipe[N_STAGES] into the gain stage
    pipe_sample_t pipe [N_STAGES+1];

    cordic_prefold u_prefold (
        .clk   (clk),
        .rst_n (rst_n),
        .s_i   (sample_i),
        .s_o   (pipe[0])
    );

    for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
        cordic_stage #(
            .SHIFT (i)
        ) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .s_i   (pipe[i]),
            .s_o   (pipe[i+1])
        );
    end

    // total latency N_STAGES+2
    cordic_gain u_gain (
        .clk   (clk),
        .rst_n (rst_n),
        .s_i   (pipe[N_STAGES]),
        .s_o   (sample_o)
    );

    // every valid register along the chain must have come out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(sample_o.valid));

endmodule

`default_nettype wire

/* include/givens_model.svh */
`ifndef GIVENS_MODEL_SVH
`define GIVENS_MODEL_SVH

localparam int MODEL_STAGES  = 8;
localparam int MODEL_LATENCY = MODEL_STAGES + 2;

typedef struct {
    int unsigned due;
    rot_sample_t smp;
} model_exp_t;

// own copy of the decisions held in the pipeline
bit         m_fold;
bit         m_dir [MODEL_STAGES];
bit         m_upd [MODEL_STAGES];
model_exp_t model_q [$];

task automatic clear_model();
    m_fold = 1'b0;
    foreach (m_dir[i]) begin
        m_dir[i] = 1'b0;
        m_upd[i] = 1'b0;
    end
    model_q.delete();
endtask

function automatic logic signed [DATA_W-1:0] scale_by_gain(input logic signed [DATA_W-1:0] v);
    longint p;
    p = longint'(v) * longint'(GAIN_K);
    return DATA_W'(p >>> GAIN_FRAC);
endfunction

function automatic rot_sample_t rotate_sample(input rot_sample_t s);
    logic signed [DATA_W-1:0] x;
    logic signed [DATA_W-1:0] y;
    logic signed [DATA_W-1:0] xs;
    logic signed [DATA_W-1:0] ys;
    bit                       vec;
    bit                       any;
    rot_sample_t              r;
    vec = (s.mode == ROT_VECTOR);
    x   = s.x;
    y   = s.y;
    any = 1'b0;
    if (vec) begin
        m_fold = (x < 0);
    end
    if (m_fold) begin
        x = -x;
        y = -y;
    end
    for (int i = 0; i < MODEL_STAGES; i++) begin
        if (vec) begin
            m_dir[i] = (y > 0);
            m_upd[i] = (y != 0);
        end
        if (m_upd[i]) begin
            xs = x >>> i;
            ys = y >>> i;
            if (m_dir[i]) begin
                x = x + ys;
                y = y - xs;
            end else begin
                x = x - ys;
                y = y + xs;
            end
            any = 1'b1;
        end
    end
    // gain only when something rotated
    if (any) begin
        x = scale_by_gain(x);
        y = scale_by_gain(y);
    end
    r   = s;
    r.x = x;
    r.y = y;
    return r;
endfunction

task automatic queue_expected(input rot_sample_t s, input int unsigned cycle);
    model_exp_t e;
    e.due = cycle + MODEL_LATENCY;
    e.smp = rotate_sample(s);
    model_q.push_back(e);
endtask

`endif

/* tb/tb_givens_rotator.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_givens_rotator
    import givens_pkg::*;
();

    localparam int STIM_CYCLES    = 2000;
    localparam int NOPRIOR_CYCLES = 24;
    // reset, stimulus, latency and drain fit well inside this
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;

    logic        clk;
    logic        rst_n;
    rot_sample_t sample_i;
    rot_sample_t sample_o;

    int          seed;
    int unsigned cycle;
    int          stim_n;
    bit          stim_done;
    bit          seen_vec;
    int          err_value;
    int          err_missing;
    int          err_extra;
    int          err_reset;
    rot_sample_t orig_q [$];
    bit          noprior_q [$];

    `include "givens_model.svh"

    givens_rotator #(
        .N_STAGES (MODEL_STAGES)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .sample_i (sample_i),
        .sample_o (sample_o)
    );

    always #20 clk = ~clk;

    task automatic report_value(input string test, input string field,
                                input int expv, input int actv);
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", test, field, expv, actv);
        err_value++;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        sample_i  = '0;
        seed      = 32'hb7c2_f590;
        cycle     = 0;
        stim_n    = 0;
        stim_done = 1'b0;
        seen_vec  = 1'b0;
        err_value   = 0;
        err_missing = 0;
        err_extra   = 0;
        err_reset   = 0;
        clear_model();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (!(stim_done && model_q.size() == 0)) begin
            @(negedge clk);
        end
        // a few more cycles to catch stray outputs
        repeat (12) @(negedge clk);
        @(posedge clk);
        $display("errors: value %0d, missing %0d, unexpected %0d, reset %0d",
                 err_value, err_missing, err_extra, err_reset);
        if (err_value + err_missing + err_extra + err_reset == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin : drive
        rot_sample_t s;
        int          kind;
        int          xv;
        int          yv;
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout at cycle %0d with %0d outputs outstanding", cycle, model_q.size());
            $display(">>> FAIL");
            $finish;
        end else begin
            s = '0;
            if (rst_n && !stim_done) begin
                kind = {$random(seed)} % 8;
                xv   = {$random(seed)} % 8001;
                yv   = {$random(seed)} % 8001;
                xv   = xv - 4000;
                yv   = yv - 4000;
                // zero y now and then so some stages skip their update
                if ({$random(seed)} % 16 == 0) begin
                    yv = 0;
                end
                s.x = xv[DATA_W-1:0];
                s.y = yv[DATA_W-1:0];
                s.valid = (kind >= 2);
                if (kind >= 2 && kind <= 4 && stim_n >= NOPRIOR_CYCLES) begin
                    s.mode = ROT_VECTOR;
                end else begin
                    s.mode = ROT_FOLLOW;
                end
                if (s.valid) begin
                    queue_expected(s, cycle);
                    orig_q.push_back(s);
                    noprior_q.push_back(!seen_vec && s.mode == ROT_FOLLOW);
                    if (s.mode == ROT_VECTOR) begin
                        seen_vec = 1'b1;
                    end
                end else begin
                    s = '0;
                end
                stim_n++;
                if (stim_n == STIM_CYCLES) begin
                    stim_done = 1'b1;
                end
            end
            sample_i <= s;
        end
    end

    always @(negedge clk) begin : check
        model_exp_t  e;
        rot_sample_t o;
        bit          np;
        string       test;
        if (cycle >= 1 && !rst_n) begin
            if (sample_o.valid !== 1'b0) begin
                $display("output valid was not low during reset at cycle %0d", cycle);
                err_reset++;
            end
        end else if (rst_n) begin
            if (model_q.size() > 0 && model_q[0].due == cycle) begin
                e  = model_q.pop_front();
                o  = orig_q.pop_front();
                np = noprior_q.pop_front();
                test = (e.smp.mode == ROT_VECTOR) ? "vectoring" : "replay";
                if (sample_o.valid !== 1'b1) begin
                    $display("missing output: no valid sample at cycle %0d", cycle);
                    err_missing++;
                end else begin
                    if (sample_o.mode !== e.smp.mode) begin
                        report_value("fixed latency", "mode",
                                     int'(e.smp.mode), int'(sample_o.mode));
                    end
                    if (sample_o.x !== e.smp.x) begin
                        report_value(test, "x", int'(e.smp.x), int'(sample_o.x));
                    end
                    if (sample_o.y !== e.smp.y) begin
                        report_value(test, "y", int'(e.smp.y), int'(sample_o.y));
                    end
                    // nothing stored yet, so the sample passes untouched
                    if (np && sample_o.x !== o.x) begin
                        report_value("no prior direction", "x", int'(o.x), int'(sample_o.x));
                    end
                    if (np && sample_o.y !== o.y) begin
                        report_value("no prior direction", "y", int'(o.y), int'(sample_o.y));
                    end
                end
            end else if (sample_o.valid !== 1'b0) begin
                $display("unexpected output: valid sample at cycle %0d with none due", cycle);
                err_extra++;
            end
        end
    end

endmodule

`default_nettype wire

/* givens_rotator.f */
+incdir+include
rtl/givens_pkg.sv
rtl/cordic_prefold.sv
rtl/cordic_stage.sv
rtl/cordic_gain.sv
rtl/givens_rotator.sv
tb/tb_givens_rotator.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Givens rotator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_givens
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_givens_rotator \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f givens_rotator.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
